/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = decode_stage_tb
FLIST = decode_stage.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: all run lint clean

all: run

$(OBJ)/V$(TOP): $(FLIST) $(shell cat $(FLIST))
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(OBJ)/V$(TOP)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ) $(LOG)

/* decode_stage.f */
src/decode_pkg.sv
src/ctrl_if.sv
src/control_decoder.sv
src/register_file.sv
src/id_ex_latch.sv
src/decode_stage.sv
sim/decode_stage_asserts.sv
sim/decode_stage_tb.sv

/* sim/decode_stage_asserts.sv */
`timescale 1ns/1ps

module decode_stage_asserts
(
	input logic                   clk,
	input logic                   reset,
	input logic                   flush,
	input logic                   stall,
	input decode_pkg::data_t      ex_pc_plus4,
	input decode_pkg::data_t      ex_imm,
	input decode_pkg::reg_addr_t  ex_rs,
	input decode_pkg::reg_addr_t  ex_rt,
	input decode_pkg::reg_addr_t  ex_rd,
	input decode_pkg::reg_addr_t  ex_shamt,
	input decode_pkg::exec_ctrl_t ex_exec,
	input decode_pkg::mem_ctrl_t  ex_mem,
	input decode_pkg::wb_ctrl_t   ex_wb,
	input decode_pkg::data_t      ex_rs_data,
	input decode_pkg::data_t      ex_rt_data,
	input logic                   ex_halt
);

	////////////////////////////////////////////////////////////
	// stage register comes out of reset empty
	reset_clears: assert property (@(posedge clk) $fell(reset) |->
		(ex_pc_plus4 == '0 && ex_imm == '0 && ex_rs == '0 && ex_rt == '0 &&
		ex_rd == '0 && ex_shamt == '0 && ex_exec == '0 && ex_mem == '0 &&
		ex_wb == '0 && ex_rs_data == '0 && ex_rt_data == '0 && !ex_halt))
		else $error("ID/EX register not clear after reset");

	no_stall_on_flush: assert property (@(posedge clk) disable iff (reset)
		flush |-> !stall)
		else $error("stall raised during flush");

	// bubble after a load-use stall
	stall_bubble: assert property (@(posedge clk) disable iff (reset)
		stall |=> (ex_exec == '0 && ex_mem == '0 && ex_wb == '0))
		else $error("control fields not cleared after stall");

endmodule

bind id_ex_latch decode_stage_asserts u_asserts
(
	.clk         (clk),
	.reset       (reset),
	.flush       (flush),
	.stall       (stall),
	.ex_pc_plus4 (ex_pc_plus4),
	.ex_imm      (ex_imm),
	.ex_rs       (ex_rs),
	.ex_rt       (ex_rt),
	.ex_rd       (ex_rd),
	.ex_shamt    (ex_shamt),
	.ex_exec     (ex_exec),
	.ex_mem      (ex_mem),
	.ex_wb       (ex_wb),
	.ex_rs_data  (ex_rs_data),
	.ex_rt_data  (ex_rt_data),
	.ex_halt     (ex_halt)
);

/* sim/decode_stage_tb.sv */
`timescale 1ns/1ps

module decode_stage_tb;

	import decode_pkg::*;

	localparam int    cols     = 26;  // hex words per vector line
	localparam int    max_vecs = 64;
	localparam string vec_file = "sim/decode_stage_vectors.txt";

	logic      clk;
	logic      reset;
	instr_t    instr;
	data_t     pc_plus4;
	logic      flush;
	logic      halt;
	logic      reg_write;
	reg_addr_t write_addr;
	data_t     write_data;
	reg_addr_t debug_addr;

	data_t      ex_pc_plus4, ex_imm, ex_rs_data, ex_rt_data;
	reg_addr_t  ex_rs, ex_rt, ex_rd, ex_shamt;
	exec_ctrl_t ex_exec;
	mem_ctrl_t  ex_mem;
	wb_ctrl_t   ex_wb;
	logic       ex_halt, jump, jump_reg, stall;
	data_t      jump_target, jump_reg_target, debug_data;

	logic [31:0] vec [max_vecs * cols];
	int          num_vecs = 0;
	int          cur;            // vector applied at the next rising edge
	logic        release_reset;

	decode_stage DUT (.*);

	always #5 clk = ~clk;

	////////////////////////////////////////////////////////////
	// stimulus applied on the rising edge
	always @(posedge clk)
	begin
		if (release_reset)
		begin
			reset <= 1'b0;
		end
		if (cur >= 0)
		begin
			instr      <= vec[cur * cols + 0];
			pc_plus4   <= vec[cur * cols + 1];
			flush      <= vec[cur * cols + 2][0];
			halt       <= vec[cur * cols + 3][0];
			reg_write  <= vec[cur * cols + 4][0];
			write_addr <= vec[cur * cols + 5][4:0];
			write_data <= vec[cur * cols + 6];
			debug_addr <= vec[cur * cols + 7][4:0];
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
			$display(">>> FAIL");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic load_vectors();
		int fd;
		fd = $fopen(vec_file, "r");
		if (fd == 0)
		begin
			$display("vector file %s could not be opened", vec_file);
			$display(">>> FAIL");
			$fatal(1, "missing vector file");
		end
		$fclose(fd);
		for (int a = 0; a < max_vecs * cols; a++)
		begin
			vec[a] = 32'hA5A5_0000 ^ 32'(a);  // words the file leaves alone keep this mark
		end
		$readmemh(vec_file, vec);
		while (num_vecs < max_vecs &&
			vec[num_vecs * cols] != (32'hA5A5_0000 ^ 32'(num_vecs * cols)))
		begin
			num_vecs++;
		end
		if (num_vecs == 0)
		begin
			$display("vector file %s is missing or holds no vectors", vec_file);
			$display(">>> FAIL");
			$fatal(1, "no vectors");
		end
	endtask

	task automatic check_reset_state();
		check_value("ex_pc_plus4", ex_pc_plus4, '0);
		check_value("ex_imm", ex_imm, '0);
		check_value("ex_rs", 32'(ex_rs), '0);
		check_value("ex_rt", 32'(ex_rt), '0);
		check_value("ex_rd", 32'(ex_rd), '0);
		check_value("ex_shamt", 32'(ex_shamt), '0);
		check_value("ex_exec", 32'(ex_exec), '0);
		check_value("ex_mem", 32'(ex_mem), '0);
		check_value("ex_wb", 32'(ex_wb), '0);
		check_value("ex_rs_data", ex_rs_data, '0);
		check_value("ex_rt_data", ex_rt_data, '0);
		check_value("ex_halt", 32'(ex_halt), '0);
		check_value("stall", 32'(stall), '0);
		check_value("jump", 32'(jump), '0);
		check_value("jump_reg", 32'(jump_reg), '0);
		check_value("debug_data", debug_data, '0);
	endtask

	// combinational outputs for the vector now on the inputs
	task automatic check_comb(input int i);
		int b;
		b = i * cols;
		check_value("stall", 32'(stall), vec[b + 8]);
		check_value("jump", 32'(jump), vec[b + 9]);
		check_value("jump_reg", 32'(jump_reg), vec[b + 10]);
		check_value("jump_target", jump_target, vec[b + 11]);
		check_value("jump_reg_target", jump_reg_target, vec[b + 12]);
		check_value("debug_data", debug_data, vec[b + 13]);
	endtask

	// ID/EX register one edge after vector i was applied
	task automatic check_regs(input int i);
		int b;
		b = i * cols;
		check_value("ex_pc_plus4", ex_pc_plus4, vec[b + 14]);
		check_value("ex_imm", ex_imm, vec[b + 15]);
		check_value("ex_rs", 32'(ex_rs), vec[b + 16]);
		check_value("ex_rt", 32'(ex_rt), vec[b + 17]);
		check_value("ex_rd", 32'(ex_rd), vec[b + 18]);
		check_value("ex_shamt", 32'(ex_shamt), vec[b + 19]);
		check_value("ex_exec", 32'(ex_exec), vec[b + 20]);
		check_value("ex_mem", 32'(ex_mem), vec[b + 21]);
		check_value("ex_wb", 32'(ex_wb), vec[b + 22]);
		check_value("ex_rs_data", ex_rs_data, vec[b + 23]);
		check_value("ex_rt_data", ex_rt_data, vec[b + 24]);
		check_value("ex_halt", 32'(ex_halt), vec[b + 25]);
	endtask

	////////////////////////////////////////////////////////////
	// main sequence samples outputs on the falling edge
	initial
	begin
		clk           = 1'b0;
		reset         = 1'b1;
		release_reset = 1'b0;
		cur           = -1;
		instr         = '0;
		pc_plus4      = '0;
		flush         = 1'b0;
		halt          = 1'b0;
		reg_write     = 1'b0;
		write_addr    = '0;
		write_data    = '0;
		debug_addr    = '0;
		load_vectors();
		@(negedge clk);
		release_reset = 1'b1;  // reset drops on the second edge
		@(negedge clk);
		check_reset_state();
		// every register reads zero through the debug port
		for (int r = 0; r < num_regs; r++)
		begin
			@(posedge clk);
			debug_addr <= reg_addr_t'(r);
			@(negedge clk);
			check_value("debug_data", debug_data, '0);
		end
		cur = 0;
		for (int i = 0; i <= num_vecs; i++)
		begin
			@(negedge clk);
			if (i < num_vecs)
			begin
				check_comb(i);
			end
			if (i > 0)
			begin
				check_regs(i - 1);
			end
			cur = (i + 1 < num_vecs) ? i + 1 : -1;
		end
		$display(">>> PASS");
		$finish;
	end

	// watchdog sized from the vector count and the register sweep
	initial
	begin
		wait (num_vecs > 0);
		#((num_vecs + num_regs + 4) * 10 + 200);
		$display("timeout: the decode stage test did not finish in time");
		$display(">>> FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

/* sim/decode_stage_vectors.txt */
// in: instr pc flush halt reg_write write_addr write_data debug_addr, then comb: stall jump
// jump_reg jump_target jump_reg_target debug_data, then ex_*: pc imm rs rt rd shamt exec mem wb
// rs_data rt_data halt (all hex)
00000000 0 0 0 1 1 1234 1F  0 0 0 0 0 0  0 0 0 0 0 0 242 0 2 0 0 0
00000000 0 0 0 1 2 5678 1  0 0 0 0 0 1234  0 0 0 0 0 0 242 0 2 0 0 0
00221820 8 0 0 1 0 FFFF 2  0 0 0 886080 1234 5678  8 1820 1 2 3 0 40 0 2 1234 5678 0
8C24FFFC C 0 0 0 0 0 0  0 0 0 93FFF0 1234 0  C FFFFFFFC 1 4 1F 1F 8 12 3 1234 0 0
00822822 10 0 0 0 0 0 0  1 0 0 208A088 0 0  10 2822 4 2 5 0 0 0 0 0 5678 0
00822822 10 0 0 0 0 0 0  0 0 0 208A088 0 0  10 2822 4 2 5 0 C0 0 2 0 5678 0
000230C0 14 0 1 0 0 0 0  0 0 0 8C300 0 0  14 30C0 0 2 6 3 242 0 2 0 5678 1
08100040 F0000020 0 0 0 0 0 0  0 1 0 F0400100 0 0  F0000020 40 0 10 0 1 20 0 0 0 0 0
00400008 24 0 0 0 0 0 0  0 0 1 1000020 5678 0  24 8 2 0 0 0 10 0 0 5678 0 0
00400008 24 1 1 0 0 0 2  0 0 0 0 0 5678  0 0 0 0 0 0 0 0 0 0 0 1
8C440008 28 0 0 0 0 0 0  0 0 0 1100020 5678 0  28 8 2 4 0 0 8 12 3 5678 0 0
2087FFFE 2C 1 0 0 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0
2087FFFE 2C 0 0 0 0 0 0  0 0 0 21FFFF8 0 0  2C FFFFFFFE 4 7 1F 1F 8 0 2 0 0 0
AC220004 30 0 0 0 0 0 0  0 0 0 880010 1234 0  30 4 1 2 0 0 8 11 0 1234 5678 0
10220010 34 0 0 0 0 0 0  0 0 0 880040 1234 0  34 10 1 2 0 0 84 0 0 1234 5678 0
00224024 38 0 0 0 0 0 0  0 0 0 890090 1234 0  38 4024 1 2 8 0 140 0 2 1234 5678 0
00224825 3C 0 0 0 0 0 0  0 0 0 892094 1234 0  3C 4825 1 2 9 0 1C0 0 2 1234 5678 0
0C000040 40 0 0 0 0 0 1  0 1 0 100 0 1234  40 40 0 0 0 1 21 0 2 0 0 0

/* src/control_decoder.sv */
`timescale 1ns/1ps

module control_decoder
(
	input  decode_pkg::instr_t instr,
	ctrl_if.decoder            ctrl
);

	import decode_pkg::*;

	opcode_t    opcode;
	opcode_t    funct;
	exec_ctrl_t exec_c;
	mem_ctrl_t  mem_c;
	wb_ctrl_t   wb_c;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];

	always_comb
	begin
		exec_c = '0;  // unknown opcode falls through as a no-op
		mem_c  = '0;
		wb_c   = '0;
		case (opcode)
			op_rtype:
			begin
				exec_c[ex_reg_dst_bit]   = 1'b1;
				wb_c[wb_reg_write_bit]   = 1'b1;
				case (funct)
					fn_add: exec_c[ex_alu_op_lsb +: $bits(alu_op_t)] = alu_add;
					fn_sub: exec_c[ex_alu_op_lsb +: $bits(alu_op_t)] = alu_sub;
					fn_and: exec_c[ex_alu_op_lsb +: $bits(alu_op_t)] = alu_and;
					fn_or:  exec_c[ex_alu_op_lsb +: $bits(alu_op_t)] = alu_or;
					fn_sll:
					begin
						exec_c[ex_alu_op_lsb +: $bits(alu_op_t)] = alu_sll;
						exec_c[ex_shift_bit] = 1'b1;  // shamt instead of rs
					end
					fn_jr:
					begin
						exec_c = '0;
						wb_c   = '0;  // jr writes nothing
						exec_c[ex_jump_reg_bit] = 1'b1;
					end
					default:
					begin
						exec_c = '0;
						wb_c   = '0;
					end
				endcase
			end
			op_addi:
			begin
				exec_c[ex_alu_op_lsb +: $bits(alu_op_t)] = alu_add;
				exec_c[ex_alu_src_bit] = 1'b1;
				wb_c[wb_reg_write_bit] = 1'b1;
			end
			op_lw:
			begin
				exec_c[ex_alu_op_lsb +: $bits(alu_op_t)] = alu_add;  // base + offset
				exec_c[ex_alu_src_bit]  = 1'b1;
				mem_c[mem_read_bit]     = 1'b1;
				mem_c[mem_word_bit]     = 1'b1;
				wb_c[wb_reg_write_bit]  = 1'b1;
				wb_c[wb_mem_to_reg_bit] = 1'b1;
			end
			op_sw:
			begin
				exec_c[ex_alu_op_lsb +: $bits(alu_op_t)] = alu_add;
				exec_c[ex_alu_src_bit] = 1'b1;
				mem_c[mem_write_bit]   = 1'b1;
				mem_c[mem_word_bit]    = 1'b1;
			end
			op_beq:
			begin
				exec_c[ex_alu_op_lsb +: $bits(alu_op_t)] = alu_sub;  // compare by subtract
				exec_c[ex_branch_bit] = 1'b1;
			end
			op_j: exec_c[ex_jump_bit] = 1'b1;
			op_jal:
			begin
				exec_c[ex_alu_op_lsb +: $bits(alu_op_t)] = alu_add;
				exec_c[ex_jump_bit]    = 1'b1;
				exec_c[ex_link_bit]    = 1'b1;  // return address goes to r31
				wb_c[wb_reg_write_bit] = 1'b1;
			end
			default: ;
		endcase
	end

	assign ctrl.exec = exec_c;
	assign ctrl.mem  = mem_c;
	assign ctrl.wb   = wb_c;

endmodule

/* src/ctrl_if.sv */
`timescale 1ns/1ps

// decoded control fields, valid combinationally for the instruction
// currently sitting in decode
interface ctrl_if;

	decode_pkg::exec_ctrl_t exec;  // alu and jump controls
	decode_pkg::mem_ctrl_t  mem;   // load/store controls
	decode_pkg::wb_ctrl_t   wb;    // write-back controls

	modport decoder
	(
		output exec,
		output mem,
		output wb
	);

	modport latch
	(
		input exec,
		input mem,
		input wb
	);

endinterface

/* src/decode_pkg.sv */
package decode_pkg;

	////////////////////////////////////////////////////////////
	// widths
	typedef logic [31:0] data_t;      // register values, pc, immediates
	typedef logic [4:0]  reg_addr_t;  // register number, also shamt
	typedef logic [31:0] instr_t;
	typedef logic [5:0]  opcode_t;    // opcode or funct
	typedef logic [3:0]  alu_op_t;
	typedef logic [10:0] exec_ctrl_t;
	typedef logic [8:0]  mem_ctrl_t;
	typedef logic [1:0]  wb_ctrl_t;

	localparam int num_regs = 32;

	////////////////////////////////////////////////////////////
	// opcodes and funct codes
	localparam opcode_t op_rtype = 6'd0;
	localparam opcode_t op_j     = 6'd2;
	localparam opcode_t op_jal   = 6'd3;
	localparam opcode_t op_beq   = 6'd4;
	localparam opcode_t op_addi  = 6'd8;
	localparam opcode_t op_lw    = 6'd35;
	localparam opcode_t op_sw    = 6'd43;

	localparam opcode_t fn_sll = 6'd0;
	localparam opcode_t fn_jr  = 6'd8;
	localparam opcode_t fn_add = 6'd32;
	localparam opcode_t fn_sub = 6'd34;
	localparam opcode_t fn_and = 6'd36;
	localparam opcode_t fn_or  = 6'd37;

	localparam alu_op_t alu_add = 4'd0;
	localparam alu_op_t alu_sub = 4'd1;
	localparam alu_op_t alu_and = 4'd2;
	localparam alu_op_t alu_or  = 4'd3;
	localparam alu_op_t alu_sll = 4'd4;

	////////////////////////////////////////////////////////////
	// control field layout
	localparam int ex_alu_op_lsb   = 7;  // alu_op in [10:7]
	localparam int ex_reg_dst_bit  = 6;
	localparam int ex_jump_bit     = 5;
	localparam int ex_jump_reg_bit = 4;
	localparam int ex_alu_src_bit  = 3;
	localparam int ex_branch_bit   = 2;
	localparam int ex_shift_bit    = 1;
	localparam int ex_link_bit     = 0;

	// bits 8:5 are left for byte, half and sign variants of loads and stores
	localparam int mem_write_bit = 0;
	localparam int mem_read_bit  = 1;
	localparam int mem_word_bit  = 4;

	localparam int wb_reg_write_bit  = 1;
	localparam int wb_mem_to_reg_bit = 0;

endpackage

/* src/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage
(
	input  logic                   clk,
	input  logic                   reset,
	input  decode_pkg::instr_t     instr,
	input  decode_pkg::data_t      pc_plus4,
	input  logic                   flush,
	input  logic                   halt,
	input  logic                   reg_write,
	input  decode_pkg::reg_addr_t  write_addr,
	input  decode_pkg::data_t      write_data,
	input  decode_pkg::reg_addr_t  debug_addr,
	output decode_pkg::data_t      ex_pc_plus4,
	output decode_pkg::data_t      ex_imm,
	output decode_pkg::reg_addr_t  ex_rs,
	output decode_pkg::reg_addr_t  ex_rt,
	output decode_pkg::reg_addr_t  ex_rd,
	output decode_pkg::reg_addr_t  ex_shamt,
	output decode_pkg::exec_ctrl_t ex_exec,
	output decode_pkg::mem_ctrl_t  ex_mem,
	output decode_pkg::wb_ctrl_t   ex_wb,
	output decode_pkg::data_t      ex_rs_data,
	output decode_pkg::data_t      ex_rt_data,
	output logic                   ex_halt,
	output logic                   jump,
	output logic                   jump_reg,
	output decode_pkg::data_t      jump_target,
	output decode_pkg::data_t      jump_reg_target,
	output logic                   stall,
	output decode_pkg::data_t      debug_data
);

	import decode_pkg::*;

	reg_addr_t rs_addr;
	reg_addr_t rt_addr;
	data_t     rs_data;
	data_t     rt_data;

	ctrl_if ctrl_bus ();  // decoder -> latch

	control_decoder u_control_decoder
	(
		.instr (instr),
		.ctrl  (ctrl_bus.decoder)
	);

	register_file u_register_file
	(
		.clk        (clk),
		.reset      (reset),
		.reg_write  (reg_write),
		.write_addr (write_addr),
		.write_data (write_data),
		.rs_addr    (rs_addr),
		.rt_addr    (rt_addr),
		.debug_addr (debug_addr),
		.rs_data    (rs_data),
		.rt_data    (rt_data),
		.debug_data (debug_data)
	);

	id_ex_latch u_id_ex_latch
	(
		.clk             (clk),
		.reset           (reset),
		.instr           (instr),
		.pc_plus4        (pc_plus4),
		.flush           (flush),
		.halt            (halt),
		.ctrl            (ctrl_bus.latch),
		.rs_data         (rs_data),
		.rt_data         (rt_data),
		.rs_addr         (rs_addr),
		.rt_addr         (rt_addr),
		.ex_pc_plus4     (ex_pc_plus4),
		.ex_imm          (ex_imm),
		.ex_rs           (ex_rs),
		.ex_rt           (ex_rt),
		.ex_rd           (ex_rd),
		.ex_shamt        (ex_shamt),
		.ex_exec         (ex_exec),
		.ex_mem          (ex_mem),
		.ex_wb           (ex_wb),
		.ex_rs_data      (ex_rs_data),
		.ex_rt_data      (ex_rt_data),
		.ex_halt         (ex_halt),
		.jump            (jump),
		.jump_reg        (jump_reg),
		.jump_target     (jump_target),
		.jump_reg_target (jump_reg_target),
		.stall           (stall)
	);

endmodule

/* src/id_ex_latch.sv */
`timescale 1ns/1ps

module id_ex_latch
(
	input  logic                   clk,
	input  logic                   reset,
	input  decode_pkg::instr_t     instr,
	input  decode_pkg::data_t      pc_plus4,
	input  logic                   flush,
	input  logic                   halt,
	ctrl_if.latch                  ctrl,
	input  decode_pkg::data_t      rs_data,
	input  decode_pkg::data_t      rt_data,
	output decode_pkg::reg_addr_t  rs_addr,
	output decode_pkg::reg_addr_t  rt_addr,
	output decode_pkg::data_t      ex_pc_plus4,
	output decode_pkg::data_t      ex_imm,
	output decode_pkg::reg_addr_t  ex_rs,
	output decode_pkg::reg_addr_t  ex_rt,
	output decode_pkg::reg_addr_t  ex_rd,
	output decode_pkg::reg_addr_t  ex_shamt,
	output decode_pkg::exec_ctrl_t ex_exec,
	output decode_pkg::mem_ctrl_t  ex_mem,
	output decode_pkg::wb_ctrl_t   ex_wb,
	output decode_pkg::data_t      ex_rs_data,
	output decode_pkg::data_t      ex_rt_data,
	output logic                   ex_halt,
	output logic                   jump,
	output logic                   jump_reg,
	output decode_pkg::data_t      jump_target,
	output decode_pkg::data_t      jump_reg_target,
	output logic                   stall
);

	import decode_pkg::*;

	reg_addr_t rd_field;
	reg_addr_t shamt_field;
	data_t     imm_ext;
	logic      load_use;

	////////////////////////////////////////////////////////////
	// field extraction
	assign rs_addr     = instr[25:21];
	assign rt_addr     = instr[20:16];
	assign rd_field    = instr[15:11];
	assign shamt_field = instr[10:6];
	assign imm_ext     = {{16{instr[15]}}, instr[15:0]};  // sign extend

	// load in EX whose destination is read here
	assign load_use = ex_mem[mem_read_bit] && ((ex_rt == rs_addr) || (ex_rt == rt_addr));
	assign stall    = load_use && !flush;

	assign jump            = !flush && ctrl.exec[ex_jump_bit];
	assign jump_reg        = !flush && ctrl.exec[ex_jump_reg_bit];
	assign jump_target     = flush ? '0 : {pc_plus4[31:28], instr[25:0], 2'b00};
	assign jump_reg_target = flush ? '0 : rs_data;

	////////////////////////////////////////////////////////////
	// ID/EX register
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			ex_pc_plus4 <= '0;
			ex_imm      <= '0;
			ex_rs       <= '0;
			ex_rt       <= '0;
			ex_rd       <= '0;
			ex_shamt    <= '0;
			ex_exec     <= '0;
			ex_mem      <= '0;
			ex_wb       <= '0;
			ex_rs_data  <= '0;
			ex_rt_data  <= '0;
			ex_halt     <= 1'b0;
		end
		else
		begin
			ex_halt <= halt;  // halt passes through even on flush
			if (flush)
			begin
				ex_pc_plus4 <= '0;
				ex_imm      <= '0;
				ex_rs       <= '0;
				ex_rt       <= '0;
				ex_rd       <= '0;
				ex_shamt    <= '0;
				ex_exec     <= '0;
				ex_mem      <= '0;
				ex_wb       <= '0;
				ex_rs_data  <= '0;
				ex_rt_data  <= '0;
			end
			else
			begin
				ex_pc_plus4 <= pc_plus4;
				ex_imm      <= imm_ext;
				ex_rs       <= rs_addr;
				ex_rt       <= rt_addr;
				ex_rd       <= rd_field;
				ex_shamt    <= shamt_field;
				ex_rs_data  <= rs_data;
				ex_rt_data  <= rt_data;
				// bubble: control goes to zero, fetch holds the instruction
				ex_exec <= stall ? '0 : ctrl.exec;
				ex_mem  <= stall ? '0 : ctrl.mem;
				ex_wb   <= stall ? '0 : ctrl.wb;
			end
		end
	end

endmodule

/* src/register_file.sv */
`timescale 1ns/1ps

module register_file
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  reg_write,
	input  decode_pkg::reg_addr_t write_addr,
	input  decode_pkg::data_t     write_data,
	input  decode_pkg::reg_addr_t rs_addr,
	input  decode_pkg::reg_addr_t rt_addr,
	input  decode_pkg::reg_addr_t debug_addr,
	output decode_pkg::data_t     rs_data,
	output decode_pkg::data_t     rt_data,
	output decode_pkg::data_t     debug_data
);

	import decode_pkg::*;

	data_t regs [num_regs];

	////////////////////////////////////////////////////////////
	// write port
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < num_regs; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (reg_write && (write_addr != '0))  // r0 stays zero
		begin
			regs[write_addr] <= write_data;
		end
	end

	////////////////////////////////////////////////////////////
	// read ports, no bypass from the write port
	assign rs_data    = regs[rs_addr];
	assign rt_data    = regs[rt_addr];
	assign debug_data = regs[debug_addr];  // debug peek, no side effects

endmodule
